//--- hdl/game_consts.svh
// Game map constants for the character movement subsystem
// Screen, sprite and step sizes plus the ladder, ramp and ramp-end rectangles
`ifndef GAME_CONSTS_SVH
`define GAME_CONSTS_SVH

// ============================================================
// screen and character
// ============================================================
`define HOR_PIXELS       1024
`define VER_PIXELS       768
`define CHAR_WIDTH       48
`define CHAR_HEIGHT      64

// the character starts on the bottom floor, feet at y = 736
`define START_X          64
`define START_Y          672

`define WALK_STEP        1
`define CLIMB_STEP       1
`define FALL_STEP        4   // pixels per tick while in the air

// ============================================================
// ladders
// ============================================================
`define LADDER_X_MARGIN  16

`define LADDER_1_HSTART     160
`define LADDER_1_HSTOP      192
`define LADDER_1_VSTART     544
`define LADDER_1_VSTOP      736
`define LADDER_1_TOP_CLEAR  64
`define LADDER_2_HSTART     800
`define LADDER_2_HSTOP      832
`define LADDER_2_VSTART     352
`define LADDER_2_VSTOP      544
`define LADDER_2_TOP_CLEAR  64
`define LADDER_3_HSTART     240
`define LADDER_3_HSTOP      272
`define LADDER_3_VSTART     160
`define LADDER_3_VSTOP      352
`define LADDER_3_TOP_CLEAR  64
`define LADDER_4_HSTART     656
`define LADDER_4_HSTOP      688
`define LADDER_4_VSTART     160
`define LADDER_4_VSTOP      352
`define LADDER_4_TOP_CLEAR  64
`define LADDER_5_HSTART     480
`define LADDER_5_HSTOP      512
`define LADDER_5_VSTART     96
`define LADDER_5_VSTOP      160
`define LADDER_5_TOP_CLEAR  96   // short top ladder stops below the floor

// ============================================================
// ramps, slope 1 rises to the right and 2 falls to the right
// ============================================================
`define RAMP_1_XMIN   576
`define RAMP_1_XMAX   1023
`define RAMP_1_YMIN   560
`define RAMP_1_YMAX   672
`define RAMP_1_SLOPE  1
`define RAMP_2_XMIN   0
`define RAMP_2_XMAX   767
`define RAMP_2_YMIN   448
`define RAMP_2_YMAX   480
`define RAMP_2_SLOPE  2
`define RAMP_3_XMIN   256
`define RAMP_3_XMAX   1023
`define RAMP_3_YMIN   256
`define RAMP_3_YMAX   288
`define RAMP_3_SLOPE  1
`define RAMP_4_XMIN   0
`define RAMP_4_XMAX   639
`define RAMP_4_YMIN   64
`define RAMP_4_YMAX   96
`define RAMP_4_SLOPE  2

// ============================================================
// ramp ends and the floor each one drops onto
// ============================================================
`define END_1_XMIN  976
`define END_1_XMAX  1023
`define END_1_YMIN  550
`define END_1_YMAX  559
`define END_1_LAND  672
`define END_2_XMIN  0
`define END_2_XMAX  32
`define END_2_YMIN  440
`define END_2_YMAX  447
`define END_2_LAND  672
`define END_3_XMIN  976
`define END_3_XMAX  1023
`define END_3_YMIN  248
`define END_3_YMAX  255
`define END_3_LAND  480
`define END_4_XMIN  0
`define END_4_XMAX  32
`define END_4_YMIN  56
`define END_4_YMAX  63
`define END_4_LAND  288

`endif

//--- hdl/game_pkg.sv
// Game package
// Types shared by the map classifier and the movement controller
`default_nettype none

package game_pkg;

    typedef logic [11:0] pos_t;   // screen coordinate in pixels

    typedef enum logic [1:0] {
        RAMP_NONE = 2'd0,
        RAMP_RISE = 2'd1,
        RAMP_FALL = 2'd2
    } ramp_t;

    typedef enum logic [1:0] {
        MV_WALK,
        MV_CLIMB,
        MV_FALL
    } move_state_t;

endpackage

`default_nettype wire

//--- hdl/ladder_control.sv
// Map classifier
// Registers ladder, ramp and ramp-end information for the current position
`timescale 1ns/1ns
`default_nettype none

`include "game_consts.svh"

module ladder_control import game_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  pos_t  xpos,
    input  pos_t  ypos,
    output logic  ladder,
    output pos_t  limit_ypos_min,
    output pos_t  limit_ypos_max,
    output ramp_t ramp,
    output logic  end_of_ramp,
    output pos_t  landing_ypos
);

    localparam int NUM_LADDERS = 5;
    localparam int NUM_RAMPS   = 4;
    localparam int NUM_ENDS    = 4;

    // ============================================================
    // map tables, index 0 is zone 1
    // ============================================================
    localparam int LAD_HSTART [NUM_LADDERS] = '{`LADDER_1_HSTART, `LADDER_2_HSTART,
        `LADDER_3_HSTART, `LADDER_4_HSTART, `LADDER_5_HSTART};
    localparam int LAD_HSTOP [NUM_LADDERS] = '{`LADDER_1_HSTOP, `LADDER_2_HSTOP,
        `LADDER_3_HSTOP, `LADDER_4_HSTOP, `LADDER_5_HSTOP};
    localparam int LAD_VSTART [NUM_LADDERS] = '{`LADDER_1_VSTART, `LADDER_2_VSTART,
        `LADDER_3_VSTART, `LADDER_4_VSTART, `LADDER_5_VSTART};
    localparam int LAD_VSTOP [NUM_LADDERS] = '{`LADDER_1_VSTOP, `LADDER_2_VSTOP,
        `LADDER_3_VSTOP, `LADDER_4_VSTOP, `LADDER_5_VSTOP};
    localparam int LAD_CLEAR [NUM_LADDERS] = '{`LADDER_1_TOP_CLEAR, `LADDER_2_TOP_CLEAR,
        `LADDER_3_TOP_CLEAR, `LADDER_4_TOP_CLEAR, `LADDER_5_TOP_CLEAR};

    localparam int RMP_XMIN [NUM_RAMPS] = '{`RAMP_1_XMIN, `RAMP_2_XMIN, `RAMP_3_XMIN, `RAMP_4_XMIN};
    localparam int RMP_XMAX [NUM_RAMPS] = '{`RAMP_1_XMAX, `RAMP_2_XMAX, `RAMP_3_XMAX, `RAMP_4_XMAX};
    localparam int RMP_YMIN [NUM_RAMPS] = '{`RAMP_1_YMIN, `RAMP_2_YMIN, `RAMP_3_YMIN, `RAMP_4_YMIN};
    localparam int RMP_YMAX [NUM_RAMPS] = '{`RAMP_1_YMAX, `RAMP_2_YMAX, `RAMP_3_YMAX, `RAMP_4_YMAX};
    localparam int RMP_SLOPE [NUM_RAMPS] = '{`RAMP_1_SLOPE, `RAMP_2_SLOPE,
        `RAMP_3_SLOPE, `RAMP_4_SLOPE};

    localparam int END_XMIN [NUM_ENDS] = '{`END_1_XMIN, `END_2_XMIN, `END_3_XMIN, `END_4_XMIN};
    localparam int END_XMAX [NUM_ENDS] = '{`END_1_XMAX, `END_2_XMAX, `END_3_XMAX, `END_4_XMAX};
    localparam int END_YMIN [NUM_ENDS] = '{`END_1_YMIN, `END_2_YMIN, `END_3_YMIN, `END_4_YMIN};
    localparam int END_YMAX [NUM_ENDS] = '{`END_1_YMAX, `END_2_YMAX, `END_3_YMAX, `END_4_YMAX};
    localparam int END_LAND [NUM_ENDS] = '{`END_1_LAND, `END_2_LAND, `END_3_LAND, `END_4_LAND};

    logic  ladder_nxt;
    logic  end_of_ramp_nxt;
    pos_t  limit_ypos_min_nxt;
    pos_t  limit_ypos_max_nxt;
    pos_t  landing_ypos_nxt;
    ramp_t ramp_nxt;

    // bounds are signed ints so a zone may start left of the screen edge
    function automatic logic in_rect(input pos_t x, input pos_t y, input int xmin,
                                     input int xmax, input int ymin, input int ymax);
        return (int'(x) >= xmin) && (int'(x) <= xmax) && (int'(y) >= ymin) && (int'(y) <= ymax);
    endfunction

    // loops run from the highest index down so that zone 1 has priority
    always_comb begin
        ladder_nxt         = 1'b0;
        limit_ypos_min_nxt = limit_ypos_min;   // limits are kept outside any ladder
        limit_ypos_max_nxt = limit_ypos_max;
        for (int i = NUM_LADDERS - 1; i >= 0; i--) begin
            if (in_rect(xpos, ypos, LAD_HSTART[i] - `LADDER_X_MARGIN,
                        LAD_HSTOP[i] - `LADDER_X_MARGIN,
                        LAD_VSTART[i] - `CHAR_HEIGHT, LAD_VSTOP[i])) begin
                ladder_nxt         = 1'b1;
                limit_ypos_min_nxt = pos_t'(LAD_VSTART[i] - `CHAR_HEIGHT);
                limit_ypos_max_nxt = pos_t'(LAD_VSTOP[i] - LAD_CLEAR[i]);
            end
        end
    end

    always_comb begin
        ramp_nxt = RAMP_NONE;
        for (int i = NUM_RAMPS - 1; i >= 0; i--) begin
            if (in_rect(xpos, ypos, RMP_XMIN[i], RMP_XMAX[i], RMP_YMIN[i], RMP_YMAX[i])) begin
                ramp_nxt = ramp_t'(RMP_SLOPE[i]);
            end
        end
    end

    always_comb begin
        end_of_ramp_nxt  = 1'b0;
        landing_ypos_nxt = landing_ypos;
        for (int i = NUM_ENDS - 1; i >= 0; i--) begin
            if (in_rect(xpos, ypos, END_XMIN[i], END_XMAX[i], END_YMIN[i], END_YMAX[i])) begin
                end_of_ramp_nxt  = 1'b1;
                landing_ypos_nxt = pos_t'(END_LAND[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ladder         <= 1'b0;
            limit_ypos_min <= '0;
            limit_ypos_max <= '0;
            ramp           <= RAMP_NONE;
            end_of_ramp    <= 1'b0;
            landing_ypos   <= '0;
        end else begin
            ladder         <= ladder_nxt;
            limit_ypos_min <= limit_ypos_min_nxt;
            limit_ypos_max <= limit_ypos_max_nxt;
            ramp           <= ramp_nxt;
            end_of_ramp    <= end_of_ramp_nxt;
            landing_ypos   <= landing_ypos_nxt;
        end
    end

    ramp_code_valid: assert property (@(posedge clk) disable iff (reset) ramp != 2'd3);

    ladder_limits_ordered: assert property (@(posedge clk) disable iff (reset)
        ladder |-> (limit_ypos_min <= limit_ypos_max));

endmodule

`default_nettype wire

//--- hdl/character_motion.sv
// Character movement controller
// Walk, climb and fall FSM that moves the sprite once per frame tick
`timescale 1ns/1ns
`default_nettype none

`include "game_consts.svh"

module character_motion import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        frame_tick,
    input  logic        btn_left,
    input  logic        btn_right,
    input  logic        btn_up,
    input  logic        btn_down,
    input  logic        ladder,
    input  logic        end_of_ramp,
    input  ramp_t       ramp,
    input  pos_t        limit_ypos_min,
    input  pos_t        limit_ypos_max,
    input  pos_t        landing_ypos,
    output pos_t        xpos,
    output pos_t        ypos,
    output move_state_t move_state
);

    localparam pos_t X_MAX = pos_t'(`HOR_PIXELS - `CHAR_WIDTH);
    localparam pos_t WALK  = pos_t'(`WALK_STEP);
    localparam pos_t CLIMB = pos_t'(`CLIMB_STEP);
    localparam pos_t FALL  = pos_t'(`FALL_STEP);

    move_state_t state_nxt;
    pos_t        xpos_nxt;
    pos_t        ypos_nxt;

    // ============================================================
    // next position and state, applied only on a tick
    // ============================================================
    always_comb begin
        state_nxt = move_state;
        xpos_nxt  = xpos;
        ypos_nxt  = ypos;
        case (move_state)
            MV_WALK: begin
                if (end_of_ramp) begin
                    state_nxt = MV_FALL;
                end else if (ladder && (btn_up || btn_down)) begin
                    state_nxt = MV_CLIMB;
                end else if (btn_right) begin
                    if (xpos < X_MAX) begin
                        xpos_nxt = (xpos > X_MAX - WALK) ? X_MAX : xpos + WALK;
                        if (ramp == RAMP_RISE) begin
                            ypos_nxt = ypos - 12'd1;
                        end else if (ramp == RAMP_FALL) begin
                            ypos_nxt = ypos + 12'd1;
                        end
                    end
                end else if (btn_left) begin
                    if (xpos > 12'd0) begin
                        xpos_nxt = (xpos < WALK) ? 12'd0 : xpos - WALK;
                        if (ramp == RAMP_RISE) begin
                            ypos_nxt = ypos + 12'd1;    // walking downhill
                        end else if (ramp == RAMP_FALL) begin
                            ypos_nxt = ypos - 12'd1;
                        end
                    end
                end
            end
            MV_CLIMB: begin
                if (btn_up) begin
                    ypos_nxt = (ypos < limit_ypos_min + CLIMB) ? limit_ypos_min : ypos - CLIMB;
                end else if (btn_down) begin
                    ypos_nxt = (ypos + CLIMB > limit_ypos_max) ? limit_ypos_max : ypos + CLIMB;
                end else if ((ypos == limit_ypos_min) || (ypos == limit_ypos_max)) begin
                    state_nxt = MV_WALK;   // stepped off at the top or bottom
                end
            end
            MV_FALL: begin
                if (ypos + FALL >= landing_ypos) begin
                    ypos_nxt  = landing_ypos;
                    state_nxt = MV_WALK;
                end else begin
                    ypos_nxt = ypos + FALL;
                end
            end
            default: begin
                state_nxt = MV_WALK;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            move_state <= MV_WALK;
            xpos       <= pos_t'(`START_X);
            ypos       <= pos_t'(`START_Y);
        end else if (frame_tick) begin
            move_state <= state_nxt;
            xpos       <= xpos_nxt;
            ypos       <= ypos_nxt;
        end
    end

    // the classifier needs a free cycle between ticks to catch up
    tick_spacing: assert property (@(posedge clk) disable iff (reset)
        frame_tick |=> !frame_tick);

    climb_in_limits: assert property (@(posedge clk) disable iff (reset)
        (move_state == MV_CLIMB) |-> ((ypos >= limit_ypos_min) && (ypos <= limit_ypos_max)));

endmodule

`default_nettype wire

//--- hdl/character_ctl.sv
// Character control top level
// Feeds the position back through the map classifier into the movement FSM
`timescale 1ns/1ns
`default_nettype none

module character_ctl import game_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        frame_tick,
    input  logic        btn_left,
    input  logic        btn_right,
    input  logic        btn_up,
    input  logic        btn_down,
    output pos_t        xpos,
    output pos_t        ypos,
    output move_state_t move_state,
    output logic        ladder,
    output ramp_t       ramp
);

    pos_t limit_ypos_min;
    pos_t limit_ypos_max;
    pos_t landing_ypos;
    logic end_of_ramp;

    ladder_control ladder_control_i (
        .clk            (clk),
        .reset          (reset),
        .xpos           (xpos),
        .ypos           (ypos),
        .ladder         (ladder),
        .limit_ypos_min (limit_ypos_min),
        .limit_ypos_max (limit_ypos_max),
        .ramp           (ramp),
        .end_of_ramp    (end_of_ramp),
        .landing_ypos   (landing_ypos)
    );

    character_motion character_motion_i (
        .clk            (clk),
        .reset          (reset),
        .frame_tick     (frame_tick),
        .btn_left       (btn_left),
        .btn_right      (btn_right),
        .btn_up         (btn_up),
        .btn_down       (btn_down),
        .ladder         (ladder),
        .end_of_ramp    (end_of_ramp),
        .ramp           (ramp),
        .limit_ypos_min (limit_ypos_min),
        .limit_ypos_max (limit_ypos_max),
        .landing_ypos   (landing_ypos),
        .xpos           (xpos),
        .ypos           (ypos),
        .move_state     (move_state)
    );

endmodule

`default_nettype wire

//--- test/character_ctl_tb.sv
// Testbench for the character control top level
// Table-driven walk, climb, ramp and fall checks followed by a random walk
`timescale 1ns/1ns
`default_nettype none

`include "game_consts.svh"

module character_ctl_tb import game_pkg::*; ();

    localparam int X_MAX         = `HOR_PIXELS - `CHAR_WIDTH;
    localparam int Y_MAX         = `VER_PIXELS - `CHAR_HEIGHT;
    localparam int NUM_ROWS      = 19;
    localparam int RANDOM_TICKS  = 300;
    localparam int RESET_TIMEOUT = 8;
    localparam int LAD1_XMIN = `LADDER_1_HSTART - `LADDER_X_MARGIN;   // left edge of the zone
    localparam int LAD1_X   = `LADDER_1_HSTART - `LADDER_X_MARGIN + 6;   // inside ladder 1's zone
    localparam int LAD1_TOP = `LADDER_1_VSTART - `CHAR_HEIGHT;
    localparam int LAD1_BOT = `LADDER_1_VSTOP - `LADDER_1_TOP_CLEAR;
    localparam int EDGE_Y   = `RAMP_1_YMIN - 1;   // floor just above ramp 1

    // buttons are packed as {left, right, up, down}
    localparam logic [3:0] BTN_NONE = 4'b0000;
    localparam logic [3:0] BTN_L    = 4'b1000;
    localparam logic [3:0] BTN_R    = 4'b0100;
    localparam logic [3:0] BTN_U    = 4'b0010;
    localparam logic [3:0] BTN_D    = 4'b0001;

    logic        clk;
    logic        reset;
    logic        frame_tick;
    logic        btn_left;
    logic        btn_right;
    logic        btn_up;
    logic        btn_down;
    pos_t        xpos;
    pos_t        ypos;
    move_state_t move_state;
    logic        ladder;
    ramp_t       ramp;

    string       row_name   [NUM_ROWS];
    logic [3:0]  row_btn    [NUM_ROWS];
    int          row_ticks  [NUM_ROWS];
    pos_t        row_x      [NUM_ROWS];
    pos_t        row_y      [NUM_ROWS];
    move_state_t row_state  [NUM_ROWS];
    logic        row_ladder [NUM_ROWS];
    ramp_t       row_ramp   [NUM_ROWS];
    int          row_count = 0;

    character_ctl dut_i (
        .clk        (clk),
        .reset      (reset),
        .frame_tick (frame_tick),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .xpos       (xpos),
        .ypos       (ypos),
        .move_state (move_state),
        .ladder     (ladder),
        .ramp       (ramp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ============================================================
    // helpers
    // ============================================================
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_pos(input string name, input pos_t expected, input pos_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %0d, actual %0d", name, expected, actual));
        end
    endtask

    task automatic check_state(input string name, input move_state_t expected,
                               input move_state_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %s, actual %s (%0d)", name,
                                expected.name(), actual.name(), actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_ramp(input string name, input ramp_t expected, input ramp_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %s, actual %s (%0d)", name,
                                expected.name(), actual.name(), actual));
        end
    endtask

    task automatic check_range(input string name, input pos_t actual, input int hi);
        if ($isunknown(actual) || int'(actual) > hi) begin
            abort_run($sformatf("ERROR %s: expected 0..%0d, actual %0d", name, hi, actual));
        end
    endtask

    // every step lands 1 ns after a rising edge
    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wait_out_of_reset();
        int cycles;
        cycles = 0;
        while ((move_state !== MV_WALK || xpos !== pos_t'(`START_X)) && cycles < RESET_TIMEOUT) begin
            wait_cycles(1);
            cycles++;
        end
        if (move_state !== MV_WALK || xpos !== pos_t'(`START_X)) begin
            abort_run("timeout: the DUT did not settle to its reset position");
        end
    endtask

    task automatic drive_buttons(input logic [3:0] b);
        {btn_left, btn_right, btn_up, btn_down} = b;
    endtask

    // one frame pulse, ending two cycles after the tick when the new flags are registered
    task automatic pulse_tick();
        frame_tick = 1'b1;
        wait_cycles(1);
        frame_tick = 1'b0;
        wait_cycles(1);
    endtask

    // a full tick slot is the pulse plus three idle cycles
    task automatic apply_tick();
        pulse_tick();
        wait_cycles(2);
    endtask

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic add_row(input string name, input logic [3:0] b, input int ticks,
                           input int x, input int y, input move_state_t st,
                           input logic lad, input ramp_t rmp);
        row_name[row_count]   = name;
        row_btn[row_count]    = b;
        row_ticks[row_count]  = ticks;
        row_x[row_count]      = pos_t'(x);
        row_y[row_count]      = pos_t'(y);
        row_state[row_count]  = st;
        row_ladder[row_count] = lad;
        row_ramp[row_count]   = rmp;
        row_count++;
    endtask

    // ============================================================
    // stimulus table, each row continues from the previous one
    // ============================================================
    task automatic load_table();
        add_row("walk_right_one", BTN_R, 1, `START_X + 1, `START_Y, MV_WALK, 1'b0, RAMP_NONE);
        add_row("walk_left_one", BTN_L, 1, `START_X, `START_Y, MV_WALK, 1'b0, RAMP_NONE);
        add_row("walk_left_edge", BTN_L, 70, 0, `START_Y, MV_WALK, 1'b0, RAMP_NONE);
        // the last tick of this row is the one that enters the ladder zone
        add_row("walk_to_ladder", BTN_R, LAD1_XMIN, LAD1_XMIN, `START_Y, MV_WALK, 1'b1,
                RAMP_NONE);
        add_row("walk_on_ladder", BTN_R, LAD1_X - LAD1_XMIN, LAD1_X, `START_Y, MV_WALK, 1'b1,
                RAMP_NONE);
        add_row("climb_enter", BTN_U, 1, LAD1_X, `START_Y, MV_CLIMB, 1'b1, RAMP_NONE);
        add_row("climb_up_one", BTN_U, 1, LAD1_X, `START_Y - 1, MV_CLIMB, 1'b1, RAMP_NONE);
        add_row("climb_up", BTN_U, 99, LAD1_X, `START_Y - 100, MV_CLIMB, 1'b1, RAMP_NONE);
        add_row("climb_to_top", BTN_U, 150, LAD1_X, LAD1_TOP, MV_CLIMB, 1'b1, RAMP_FALL);
        add_row("leave_at_top", BTN_NONE, 1, LAD1_X, LAD1_TOP, MV_WALK, 1'b1, RAMP_FALL);
        add_row("climb_down_enter", BTN_D, 1, LAD1_X, LAD1_TOP, MV_CLIMB, 1'b1, RAMP_FALL);
        add_row("climb_down", BTN_D, 200, LAD1_X, LAD1_BOT, MV_CLIMB, 1'b1, RAMP_NONE);
        add_row("leave_at_bottom", BTN_NONE, 1, LAD1_X, LAD1_BOT, MV_WALK, 1'b1, RAMP_NONE);
        add_row("walk_to_ramp", BTN_R, `RAMP_1_XMIN - LAD1_X, `RAMP_1_XMIN, `START_Y,
                MV_WALK, 1'b0, RAMP_RISE);
        add_row("ramp_step", BTN_R, 1, `RAMP_1_XMIN + 1, `START_Y - 1, MV_WALK, 1'b0, RAMP_RISE);
        // 112 steps up the ramp, then flat floor up to the ramp end
        add_row("walk_to_ramp_end", BTN_R, 399, `END_1_XMIN, EDGE_Y, MV_WALK, 1'b0, RAMP_NONE);
        add_row("start_fall", BTN_NONE, 1, `END_1_XMIN, EDGE_Y, MV_FALL, 1'b0, RAMP_NONE);
        add_row("fall_midway", BTN_NONE, 10, `END_1_XMIN, EDGE_Y + 10 * `FALL_STEP,
                MV_FALL, 1'b0, RAMP_RISE);
        add_row("fall_land", BTN_NONE, 19, `END_1_XMIN, `END_1_LAND, MV_WALK, 1'b0, RAMP_RISE);
    endtask

    initial begin
        logic [31:0] seed;
        seed = 32'h92fc15fd;
        reset = 1'b1;
        frame_tick = 1'b0;
        drive_buttons(BTN_NONE);
        wait_cycles(2);
        reset = 1'b0;
        wait_out_of_reset();

        check_pos("reset xpos", pos_t'(`START_X), xpos);
        check_pos("reset ypos", pos_t'(`START_Y), ypos);
        check_state("reset move_state", MV_WALK, move_state);
        check_flag("reset ladder", 1'b0, ladder);
        check_ramp("reset ramp", RAMP_NONE, ramp);

        load_table();
        for (int r = 0; r < row_count; r++) begin
            drive_buttons(row_btn[r]);
            for (int t = 0; t < row_ticks[r]; t++) begin
                pulse_tick();
                if (t == row_ticks[r] - 1) begin
                    // flags of the new position are due two cycles after the tick
                    check_flag({row_name[r], " ladder"}, row_ladder[r], ladder);
                    check_ramp({row_name[r], " ramp"}, row_ramp[r], ramp);
                end
                wait_cycles(2);
            end
            check_pos({row_name[r], " xpos"}, row_x[r], xpos);
            check_pos({row_name[r], " ypos"}, row_y[r], ypos);
            check_state({row_name[r], " move_state"}, row_state[r], move_state);
        end

        // random walk from wherever the table left the character
        for (int t = 0; t < RANDOM_TICKS; t++) begin
            seed = lcg_next(seed);
            drive_buttons(seed[31:28]);
            apply_tick();
            check_range("random_walk xpos", xpos, X_MAX);
            check_range("random_walk ypos", ypos, Y_MAX);
            if (ramp === 2'd3) begin
                abort_run("the classifier reported the unused ramp code 3");
            end
        end

        drive_buttons(BTN_NONE);
        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+hdl
hdl/game_pkg.sv
hdl/ladder_control.sv
hdl/character_motion.sv
hdl/character_ctl.sv
test/character_ctl_tb.sv

//--- Bender.yml
package:
  name: character_ctl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/game_pkg.sv
      - hdl/ladder_control.sv
      - hdl/character_motion.sv
      - hdl/character_ctl.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - test/character_ctl_tb.sv
